//--- common/hci_pkg.sv
/* Shared types and constants for the host debug interface.
   Every block refers to these by scoped name, as hci_pkg::name. */

package hci_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic data types
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;     // Serial and CPU data byte
  typedef logic [15:0] word_t;     // CPU address or burst count
  typedef logic [3:0]  reg_sel_t;  // CPU debug register select

  // Address and count words, filled one header byte at a time
  // and used as a whole word once complete
  typedef union packed
  {
    word_t w;      // Whole 16-bit view
    struct packed
    {
      byte_t hi;   // Second header byte
      byte_t lo;   // First header byte
    } b;
  } hci_word_u;

  //////////////////////////////////////////////////////////////////////
  // Packet opcodes
  //////////////////////////////////////////////////////////////////////

  // First byte of every host packet
  // 8'h09 to 8'h0C once served PPU access and now decode as unknown
  typedef enum logic [7:0]
  {
    op_echo           = 8'h00,  // cnt lo, cnt hi, data...
    op_cpu_mem_rd     = 8'h01,  // addr lo, addr hi, cnt lo, cnt hi
    op_cpu_mem_wr     = 8'h02,  // addr lo, addr hi, cnt lo, cnt hi, data...
    op_dbg_brk        = 8'h03,  // Halt the CPU
    op_dbg_run        = 8'h04,  // Release the CPU
    op_cpu_reg_rd     = 8'h05,  // sel
    op_cpu_reg_wr     = 8'h06,  // sel, data
    op_query_dbg_brk  = 8'h07,  // Reply 1 if halted, else 0
    op_query_err_code = 8'h08   // Reply error code byte
  } op_e;

  //////////////////////////////////////////////////////////////////////
  // Error code bits
  //////////////////////////////////////////////////////////////////////

  // Sticky until reset
  localparam int err_parity_bit     = 0;  // Bad parity on a received byte
  localparam int err_unknown_op_bit = 1;  // Opcode not in op_e

endpackage

//--- source/uart_rx.sv
/* Serial receiver, 8 data bits, odd parity, one stop bit.
   Holds one byte for the command engine until it is popped with rd_en. */

module uart_rx
#(
  parameter int CLKS_PER_BIT = 16
)
(
  input  logic           clk,
  input  logic           rst,
  input  logic           rx,          // Serial line, idles high
  input  logic           rd_en,       // Pop the held byte
  output hci_pkg::byte_t rx_data,
  output logic           rx_empty,
  output logic           parity_err   // One-cycle pulse with the byte
);

localparam int CW = $clog2(CLKS_PER_BIT);
localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} rx_state_e;

rx_state_e      q_state;
logic [1:0]     q_sync;   // Two-flop synchronizer, [1] is safe
logic [CW-1:0]  q_cnt;    // Clocks into current bit
logic [2:0]     q_bit;    // Data bit index
logic           q_full;
logic           q_perr;
hci_pkg::byte_t q_shift;  // Incoming data, LSB first
logic           q_par;
hci_pkg::byte_t q_hold;   // Byte waiting for the engine

logic line;
logic bit_mid;  // Middle of a data, parity or stop bit

assign line    = q_sync[1];
assign bit_mid = (q_cnt == BIT_LAST);

// Control state
always_ff @(posedge clk)
begin
  if (rst)
  begin
    q_state <= st_idle;
    q_sync  <= 2'b11;
    q_cnt   <= '0;
    q_bit   <= '0;
    q_full  <= 1'b0;
    q_perr  <= 1'b0;
  end
  else
  begin
    q_sync <= {q_sync[0], rx};
    q_perr <= 1'b0;
    if (rd_en)
      q_full <= 1'b0;                     // Popped by engine

    q_cnt <= bit_mid ? '0 : q_cnt + 1'b1;
    case (q_state)
      st_idle:
      begin
        q_cnt <= '0;
        if (!line)
          q_state <= st_start;            // Falling start edge
      end
      st_start:
      begin
        if (q_cnt == HALF_LAST)           // Middle of start bit
        begin
          q_cnt   <= '0;
          q_bit   <= '0;
          q_state <= line ? st_idle : st_data;  // Glitch goes back to idle
        end
      end
      st_data:
      begin
        if (bit_mid)
        begin
          q_bit <= q_bit + 3'd1;
          if (q_bit == 3'd7)
            q_state <= st_parity;
        end
      end
      st_parity:
        if (bit_mid)
          q_state <= st_stop;
      st_stop:
      begin
        if (bit_mid)
        begin
          // Byte is delivered even with bad parity
          q_full  <= 1'b1;
          q_perr  <= ~(^{q_shift, q_par});  // Odd parity expects a 1
          q_state <= st_idle;
        end
      end
      default:
        q_state <= st_idle;
    endcase
  end
end

// Data path
always_ff @(posedge clk)
begin
  if (q_state == st_data && bit_mid)
    q_shift <= {line, q_shift[7:1]};     // LSB arrives first
  if (q_state == st_parity && bit_mid)
    q_par <= line;
  if (q_state == st_stop && bit_mid)
    q_hold <= q_shift;                   // Overwrites if still full
end

assign rx_data    = q_hold;
assign rx_empty   = ~q_full;
assign parity_err = q_perr;

endmodule

//--- source/uart_tx.sv
/* Serial transmitter, 8 data bits, odd parity, one stop bit.
   Takes one byte on wr_en; tx_full stays high until the frame is out. */

module uart_tx
#(
  parameter int CLKS_PER_BIT = 16
)
(
  input  logic           clk,
  input  logic           rst,
  input  hci_pkg::byte_t tx_data,
  input  logic           wr_en,    // Load a byte, only while not full
  output logic           tx,       // Serial line, idles high
  output logic           tx_full
);

localparam int CW = $clog2(CLKS_PER_BIT);
localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

logic          q_busy;
logic          q_tx;
logic [CW-1:0] q_cnt;   // Clocks into current bit
logic [3:0]    q_bit;   // 0 is start, 10 is stop
logic [9:0]    q_shift; // Data, parity and stop still to go

logic load;
logic bit_end;

assign load    = wr_en && !q_busy;
assign bit_end = (q_cnt == BIT_LAST);

// Control state
always_ff @(posedge clk)
begin
  if (rst)
  begin
    q_busy <= 1'b0;
    q_tx   <= 1'b1;
    q_cnt  <= '0;
    q_bit  <= '0;
  end
  else if (load)
  begin
    q_busy <= 1'b1;
    q_tx   <= 1'b0;   // Start bit goes out next cycle
    q_cnt  <= '0;
    q_bit  <= '0;
  end
  else if (q_busy)
  begin
    q_cnt <= bit_end ? '0 : q_cnt + 1'b1;
    if (bit_end)
    begin
      if (q_bit == 4'd10)
        q_busy <= 1'b0;     // Stop bit done, line stays high
      else
      begin
        q_tx  <= q_shift[0];
        q_bit <= q_bit + 4'd1;
      end
    end
  end
end

// Frame shifter
always_ff @(posedge clk)
begin
  if (load)
    q_shift <= {1'b1, ~^tx_data, tx_data};  // Stop, odd parity, data
  else if (q_busy && bit_end)
    q_shift <= {1'b1, q_shift[9:1]};
end

assign tx      = q_tx;
assign tx_full = q_busy;

endmodule

//--- cmd_engine/cmd_engine.sv
/* Packet decoder and executor for the host debug interface.
   Pops bytes from uart_rx, drives the CPU buses and queues replies to uart_tx. */

module cmd_engine
(
  input  logic              clk,
  input  logic              rst,
  input  logic              brk,             // CPU-initiated break
  input  hci_pkg::byte_t    rx_data,
  input  logic              rx_empty,
  input  logic              parity_err,
  input  logic              tx_full,
  input  hci_pkg::byte_t    cpu_din,         // CPU memory read data
  input  hci_pkg::byte_t    cpu_dbgreg_in,   // CPU debug register read data
  output logic              rd_en,
  output hci_pkg::byte_t    tx_data,
  output logic              wr_en,
  output logic              active,          // CPU halted
  output logic              cpu_r_nw,
  output hci_pkg::word_t    cpu_a,
  output hci_pkg::byte_t    cpu_dout,
  output hci_pkg::reg_sel_t cpu_dbgreg_sel,
  output hci_pkg::byte_t    cpu_dbgreg_out,
  output logic              cpu_dbgreg_wr
);

typedef enum logic [3:0]
{
  s_disabled,     // CPU running
  s_decode,       // Waiting for opcode
  s_hdr,          // Address and count bytes
  s_echo_data,
  s_mem_rd_data,
  s_mem_wr_data,
  s_reg_rd,
  s_reg_wr_sel,
  s_reg_wr_data,
  s_err_reply
} state_e;

state_e             q_state,   d_state;
state_e             q_next,    d_next;     // Data state after header
logic [1:0]         q_hdr_cnt, d_hdr_cnt;  // Header byte index
logic               q_phase,   d_phase;    // Memory read, 0 is dummy cycle
hci_pkg::hci_word_u q_addr,    d_addr;
hci_pkg::hci_word_u q_cnt,     d_cnt;      // Bytes left in burst
hci_pkg::reg_sel_t  q_sel,     d_sel;
logic [1:0]         q_err,     d_err;
hci_pkg::byte_t     q_tx_data, d_tx_data;
logic               q_wr_en,   d_wr_en;

logic tx_busy;     // Also covers the cycle before tx_full rises
logic hold_query;  // Break query cannot reply yet

assign tx_busy    = tx_full || q_wr_en;
assign hold_query = (rx_data == hci_pkg::op_query_dbg_brk) && tx_busy;

//////////////////////////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
  if (rst)
  begin
    q_state   <= s_disabled;
    q_next    <= s_decode;
    q_hdr_cnt <= '0;
    q_phase   <= 1'b0;
    q_addr    <= '0;
    q_err     <= '0;
    q_wr_en   <= 1'b0;
  end
  else
  begin
    q_state   <= d_state;
    q_next    <= d_next;
    q_hdr_cnt <= d_hdr_cnt;
    q_phase   <= d_phase;
    q_addr    <= d_addr;
    q_err     <= d_err;
    q_wr_en   <= d_wr_en;
  end
end

always_ff @(posedge clk)
begin
  q_cnt     <= d_cnt;
  q_sel     <= d_sel;
  q_tx_data <= d_tx_data;
end

//////////////////////////////////////////////////////////////////////
// Next state and CPU strobes
//////////////////////////////////////////////////////////////////////

always_comb
begin
  d_state   = q_state;
  d_next    = q_next;
  d_hdr_cnt = q_hdr_cnt;
  d_phase   = q_phase;
  d_addr    = q_addr;
  d_cnt     = q_cnt;
  d_sel     = q_sel;
  d_err     = q_err;
  d_tx_data = q_tx_data;
  d_wr_en   = 1'b0;

  rd_en          = 1'b0;
  cpu_r_nw       = 1'b1;
  cpu_dbgreg_sel = '0;
  cpu_dbgreg_out = '0;
  cpu_dbgreg_wr  = 1'b0;

  if (parity_err)
    d_err[hci_pkg::err_parity_bit] = 1'b1;

  case (q_state)
    s_disabled:
    begin
      if (brk)
        d_state = s_decode;               // Break from the CPU
      else if (!rx_empty && !hold_query)
      begin
        rd_en = 1'b1;                     // Other opcodes dropped here
        if (rx_data == hci_pkg::op_dbg_brk)
          d_state = s_decode;
        else if (rx_data == hci_pkg::op_query_dbg_brk)
        begin
          d_tx_data = 8'h00;              // Not halted
          d_wr_en   = 1'b1;
        end
      end
    end

    s_decode:
    begin
      if (!rx_empty && !hold_query)
      begin
        rd_en     = 1'b1;
        d_phase   = 1'b0;
        d_hdr_cnt = 2'd0;                 // Address first
        case (rx_data)
          hci_pkg::op_echo:
          begin
            d_hdr_cnt = 2'd2;             // Count only
            d_next    = s_echo_data;
            d_state   = s_hdr;
          end
          hci_pkg::op_cpu_mem_rd:
          begin
            d_next  = s_mem_rd_data;
            d_state = s_hdr;
          end
          hci_pkg::op_cpu_mem_wr:
          begin
            d_next  = s_mem_wr_data;
            d_state = s_hdr;
          end
          hci_pkg::op_dbg_brk:        d_state = s_decode;  // Already halted
          hci_pkg::op_dbg_run:        d_state = s_disabled;
          hci_pkg::op_cpu_reg_rd:     d_state = s_reg_rd;
          hci_pkg::op_cpu_reg_wr:     d_state = s_reg_wr_sel;
          hci_pkg::op_query_err_code: d_state = s_err_reply;
          hci_pkg::op_query_dbg_brk:
          begin
            d_tx_data = 8'h01;            // Halted
            d_wr_en   = 1'b1;
          end
          default:
            d_err[hci_pkg::err_unknown_op_bit] = 1'b1;
        endcase
      end
    end

    // Header fill, lo byte before hi byte
    s_hdr:
    begin
      if (!rx_empty)
      begin
        rd_en     = 1'b1;
        d_hdr_cnt = q_hdr_cnt + 2'd1;
        case (q_hdr_cnt)
          2'd0: d_addr.b.lo = rx_data;
          2'd1: d_addr.b.hi = rx_data;
          2'd2: d_cnt.b.lo  = rx_data;
          default:
          begin
            d_cnt.b.hi = rx_data;
            d_state    = (d_cnt.w == '0) ? s_decode : q_next;  // Empty burst
          end
        endcase
      end
    end

    s_echo_data:
    begin
      if (!rx_empty && !tx_busy)
      begin
        rd_en     = 1'b1;
        d_tx_data = rx_data;
        d_wr_en   = 1'b1;
        d_cnt.w   = q_cnt.w - 16'd1;
        if (q_cnt.w == 16'd1)
          d_state = s_decode;
      end
    end

    // Two cycles per byte, dummy cycle lets cpu_din and tx_full settle
    s_mem_rd_data:
    begin
      if (!q_phase)
        d_phase = 1'b1;
      else if (!tx_busy)                  // Otherwise address holds
      begin
        d_phase   = 1'b0;
        d_tx_data = cpu_din;
        d_wr_en   = 1'b1;
        d_addr.w  = q_addr.w + 16'd1;
        d_cnt.w   = q_cnt.w - 16'd1;
        if (q_cnt.w == 16'd1)
          d_state = s_decode;
      end
    end

    s_mem_wr_data:
    begin
      if (!rx_empty)
      begin
        rd_en    = 1'b1;
        cpu_r_nw = 1'b0;                  // cpu_dout is rx_data
        d_addr.w = q_addr.w + 16'd1;
        d_cnt.w  = q_cnt.w - 16'd1;
        if (q_cnt.w == 16'd1)
          d_state = s_decode;
      end
    end

    s_reg_rd:
    begin
      if (!rx_empty && !tx_busy)
      begin
        rd_en          = 1'b1;
        cpu_dbgreg_sel = rx_data[3:0];
        d_tx_data      = cpu_dbgreg_in;
        d_wr_en        = 1'b1;
        d_state        = s_decode;
      end
    end

    s_reg_wr_sel:
    begin
      if (!rx_empty)
      begin
        rd_en   = 1'b1;
        d_sel   = rx_data[3:0];
        d_state = s_reg_wr_data;
      end
    end

    s_reg_wr_data:
    begin
      if (!rx_empty)
      begin
        rd_en          = 1'b1;
        cpu_dbgreg_sel = q_sel;
        cpu_dbgreg_out = rx_data;
        cpu_dbgreg_wr  = 1'b1;
        d_state        = s_decode;
      end
    end

    s_err_reply:
    begin
      if (!tx_busy)
      begin
        d_tx_data = {6'b000000, q_err};
        d_wr_en   = 1'b1;
        d_state   = s_decode;
      end
    end

    default:
      d_state = s_disabled;
  endcase
end

assign active   = (q_state != s_disabled);
assign cpu_a    = q_addr.w;
assign cpu_dout = rx_data;   // Write data straight from the receiver
assign tx_data  = q_tx_data;
assign wr_en    = q_wr_en;

endmodule

//--- source/hci_top.sv
/* Top level of the host debug interface.
   Serial pins on one side, CPU debug buses on the other. */

module hci_top
#(
  parameter int CLKS_PER_BIT = 16  // Clocks per serial bit
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rx,
  input  logic              brk,
  input  hci_pkg::byte_t    cpu_din,
  input  hci_pkg::byte_t    cpu_dbgreg_in,
  output logic              tx,
  output logic              active,
  output logic              cpu_r_nw,
  output hci_pkg::word_t    cpu_a,
  output hci_pkg::byte_t    cpu_dout,
  output hci_pkg::reg_sel_t cpu_dbgreg_sel,
  output hci_pkg::byte_t    cpu_dbgreg_out,
  output logic              cpu_dbgreg_wr
);

// Receive side
hci_pkg::byte_t rx_data;
logic           rx_empty;
logic           parity_err;
logic           rd_en;

// Transmit side
hci_pkg::byte_t tx_data;
logic           wr_en;
logic           tx_full;

uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx
(
  .clk        (clk),
  .rst        (rst),
  .rx         (rx),
  .rd_en      (rd_en),
  .rx_data    (rx_data),
  .rx_empty   (rx_empty),
  .parity_err (parity_err)
);

cmd_engine i_cmd_engine
(
  .clk            (clk),
  .rst            (rst),
  .brk            (brk),
  .rx_data        (rx_data),
  .rx_empty       (rx_empty),
  .parity_err     (parity_err),
  .tx_full        (tx_full),
  .cpu_din        (cpu_din),
  .cpu_dbgreg_in  (cpu_dbgreg_in),
  .rd_en          (rd_en),
  .tx_data        (tx_data),
  .wr_en          (wr_en),
  .active         (active),
  .cpu_r_nw       (cpu_r_nw),
  .cpu_a          (cpu_a),
  .cpu_dout       (cpu_dout),
  .cpu_dbgreg_sel (cpu_dbgreg_sel),
  .cpu_dbgreg_out (cpu_dbgreg_out),
  .cpu_dbgreg_wr  (cpu_dbgreg_wr)
);

uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx
(
  .clk     (clk),
  .rst     (rst),
  .tx_data (tx_data),
  .wr_en   (wr_en),
  .tx      (tx),
  .tx_full (tx_full)
);

endmodule

//--- sim/hci_checker.sv
/* Assertions on the hci_top ports and the engine to transmitter handshake.
   Bound into every hci_top instance from the testbench. */

module hci_checker
(
  input logic clk,
  input logic rst,
  input logic tx,
  input logic active,
  input logic cpu_r_nw,
  input logic cpu_dbgreg_wr,
  input logic wr_en,     // Engine load strobe to uart_tx
  input logic tx_full
);

timeunit 1ns;
timeprecision 1ps;

int fail_cnt = 0;  // Read by the testbench summary

//////////////////////////////////////////////////////////////////////
// CPU side strobes
//////////////////////////////////////////////////////////////////////

// Memory writes only while the CPU is halted
mem_wr_halted: assert property (@(posedge clk) disable iff (rst) !cpu_r_nw |-> active)
  else
  begin
    $error("cpu_r_nw low while active is low");
    fail_cnt++;
  end

reg_wr_halted: assert property (@(posedge clk) disable iff (rst) cpu_dbgreg_wr |-> active)
  else
  begin
    $error("cpu_dbgreg_wr high while active is low");
    fail_cnt++;
  end

//////////////////////////////////////////////////////////////////////
// Transmit handshake and reset values
//////////////////////////////////////////////////////////////////////

// One byte in flight at a time
no_wr_when_full: assert property (@(posedge clk) disable iff (rst) !(wr_en && tx_full))
  else
  begin
    $error("wr_en raised while tx_full is high");
    fail_cnt++;
  end

reset_values: assert property (@(posedge clk) rst |=> (tx && !active))
  else
  begin
    $error("tx low or active high in the cycle after reset");
    fail_cnt++;
  end

endmodule

//--- sim/hci_tb.sv
/* Testbench for hci_top. Sends host packets on rx, decodes replies on tx
   and models CPU memory and debug registers around the DUT. */

module hci_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int clks_per_bit = 16;
localparam int bit_ns       = clks_per_bit * 100;  // 100 ns clock
localparam int frame_cyc    = 11 * clks_per_bit;   // One serial frame
localparam int n_echo       = 5;
localparam int n_burst      = 8;                   // Long enough to stall on tx_full
// Bytes sent plus bytes received, test by test
localparam int bytes_total  = 6 + (3 + 2 * n_echo) + (10 + 2 * n_burst) + 6 + 6;
localparam int watchdog_ns  = bytes_total * 11 * bit_ns * 2;

logic              clk;
logic              rst;
logic              rx;
logic              brk;
hci_pkg::byte_t    cpu_din;
hci_pkg::byte_t    cpu_dbgreg_in;
logic              tx;
logic              active;
logic              cpu_r_nw;
hci_pkg::word_t    cpu_a;
hci_pkg::byte_t    cpu_dout;
hci_pkg::reg_sel_t cpu_dbgreg_sel;
hci_pkg::byte_t    cpu_dbgreg_out;
logic              cpu_dbgreg_wr;

hci_pkg::byte_t    mem [0:65535];      // CPU address space
hci_pkg::byte_t    reply_q [$];        // Decoded tx bytes
int                mem_wr_cnt = 0;
int                reg_wr_cnt = 0;
hci_pkg::reg_sel_t reg_wr_sel = '0;
hci_pkg::byte_t    reg_wr_data = '0;
logic [31:0]       lfsr = 32'h96ad_7915;
int                errors = 0;
int                tests_run = 0;
int                tests_failed = 0;

hci_top #(.CLKS_PER_BIT(clks_per_bit)) i_dut
(
  .clk            (clk),
  .rst            (rst),
  .rx             (rx),
  .brk            (brk),
  .cpu_din        (cpu_din),
  .cpu_dbgreg_in  (cpu_dbgreg_in),
  .tx             (tx),
  .active         (active),
  .cpu_r_nw       (cpu_r_nw),
  .cpu_a          (cpu_a),
  .cpu_dout       (cpu_dout),
  .cpu_dbgreg_sel (cpu_dbgreg_sel),
  .cpu_dbgreg_out (cpu_dbgreg_out),
  .cpu_dbgreg_wr  (cpu_dbgreg_wr)
);

bind hci_top hci_checker i_checker
(
  .clk           (clk),
  .rst           (rst),
  .tx            (tx),
  .active        (active),
  .cpu_r_nw      (cpu_r_nw),
  .cpu_dbgreg_wr (cpu_dbgreg_wr),
  .wr_en         (wr_en),
  .tx_full       (tx_full)
);

//////////////////////////////////////////////////////////////////////
// CPU model
//////////////////////////////////////////////////////////////////////

assign cpu_din       = mem[cpu_a];                       // Asynchronous read
assign cpu_dbgreg_in = {4'h0, cpu_dbgreg_sel} ^ 8'hA5;

always @(posedge clk)
begin
  if (!cpu_r_nw)
  begin
    mem[cpu_a] <= cpu_dout;
    mem_wr_cnt <= mem_wr_cnt + 1;
  end
  if (cpu_dbgreg_wr)
  begin
    reg_wr_cnt  <= reg_wr_cnt + 1;   // Last strobe kept for the test
    reg_wr_sel  <= cpu_dbgreg_sel;
    reg_wr_data <= cpu_dbgreg_out;
  end
end

initial
begin
  clk = 1'b0;
  forever #50 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_byte(output hci_pkg::byte_t b);
  int k;
  b = '0;
  for (k = 0; k < 8; k++)
  begin
    lfsr = lfsr_step(lfsr);        // One step per bit
    b    = {b[6:0], lfsr[0]};
  end
endtask

task automatic step();
  @(posedge clk);
  #1;
endtask

// Start, 8 data LSB first, parity, stop, then one idle bit
task automatic send_byte(input hci_pkg::byte_t b, input logic bad_par);
  logic [10:0] frame;
  int          k;
  frame = {1'b1, (~^b) ^ bad_par, b, 1'b0};
  for (k = 0; k < 12; k++)
  begin
    rx = (k < 11) ? frame[k] : 1'b1;
    repeat (clks_per_bit) @(posedge clk);
    #1;
  end
endtask

task automatic send_word(input hci_pkg::word_t w);
  send_byte(w[7:0], 1'b0);         // Low byte first
  send_byte(w[15:8], 1'b0);
endtask

task automatic check_val(input string name, input hci_pkg::byte_t got,
                         input hci_pkg::byte_t exp);
  if (got !== exp)
  begin
    errors++;
    $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic expect_reply(input hci_pkg::byte_t exp, input string what);
  int n;
  n = 0;
  while (reply_q.size() == 0 && n < 4 * frame_cyc)
  begin
    step();
    n++;
  end
  if (reply_q.size() == 0)
  begin
    errors++;
    $display("No reply byte arrived on tx for %s", what);
  end
  else
    check_val($sformatf("tx (%s)", what), reply_q.pop_front(), exp);
endtask

task automatic wait_active(input logic exp);
  int n;
  n = 0;
  while (active !== exp && n < 2 * frame_cyc)
  begin
    step();
    n++;
  end
  if (active !== exp)
  begin
    errors++;
    $display("active did not change to %0b in time", exp);
  end
endtask

task automatic end_test(input string name, input int err_before);
  tests_run++;
  if (errors != err_before)
    tests_failed++;
  $display("Test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "errors");
endtask

//////////////////////////////////////////////////////////////////////
// Serial monitor, watchdog
//////////////////////////////////////////////////////////////////////

initial
begin : tx_monitor
  hci_pkg::byte_t b;
  logic           par;
  int             k;
  forever
  begin
    @(negedge tx);
    #(bit_ns / 2);                   // Middle of start bit
    for (k = 0; k < 8; k++)
    begin
      #(bit_ns);
      b[k] = tx;
    end
    #(bit_ns);
    par = tx;
    #(bit_ns);
    if (tx !== 1'b1)
    begin
      errors++;
      $display("Reply frame for byte 0x%h has no stop bit", b);
    end
    if (^{b, par} !== 1'b1)
    begin
      errors++;
      $display("Reply frame for byte 0x%h does not have odd parity", b);
    end
    reply_q.push_back(b);
  end
end

initial
begin
  #(watchdog_ns);
  $display("Watchdog expired, the tests did not finish in the time allowed");
  $display("Simulation finished: FAIL");
  $finish;
end

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

initial
begin
  int                err0;
  int                i;
  int                n;
  hci_pkg::byte_t    echo_data [n_echo];
  hci_pkg::byte_t    burst_data [n_burst];
  hci_pkg::byte_t    rb;
  hci_pkg::byte_t    reg_data;
  hci_pkg::reg_sel_t sel;
  hci_pkg::word_t    burst_addr;

  rst = 1'b1;
  rx  = 1'b1;
  brk = 1'b0;
  for (i = 0; i < 65536; i++)
    mem[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'h3C;   // Both address bytes matter
  repeat (4) @(posedge clk);
  #1;
  rst = 1'b0;

  // Break, run and break query
  err0 = errors;
  send_byte(hci_pkg::op_query_dbg_brk, 1'b0);
  expect_reply(8'h00, "break query while running");
  send_byte(hci_pkg::op_dbg_brk, 1'b0);
  wait_active(1'b1);
  send_byte(hci_pkg::op_query_dbg_brk, 1'b0);
  expect_reply(8'h01, "break query while halted");
  send_byte(hci_pkg::op_dbg_run, 1'b0);
  wait_active(1'b0);
  brk = 1'b1;                        // CPU side break
  step();
  brk = 1'b0;
  wait_active(1'b1);
  end_test("break state", err0);

  err0 = errors;
  send_byte(hci_pkg::op_echo, 1'b0);
  send_word(16'(n_echo));
  for (i = 0; i < n_echo; i++)
  begin
    rand_byte(echo_data[i]);
    send_byte(echo_data[i], 1'b0);
  end
  for (i = 0; i < n_echo; i++)
    expect_reply(echo_data[i], "echo");
  end_test("echo", err0);

  // Burst write then read back across a page boundary
  err0 = errors;
  burst_addr = 16'h07FC;
  send_byte(hci_pkg::op_cpu_mem_wr, 1'b0);
  send_word(burst_addr);
  send_word(16'(n_burst));
  for (i = 0; i < n_burst; i++)
  begin
    rand_byte(burst_data[i]);
    send_byte(burst_data[i], 1'b0);
  end
  n = 0;
  while (mem_wr_cnt < n_burst && n < frame_cyc)
  begin
    step();
    n++;
  end
  check_val("cpu_r_nw low pulses", 8'(mem_wr_cnt), 8'(n_burst));
  for (i = 0; i < n_burst; i++)
    check_val($sformatf("mem[%h]", burst_addr + 16'(i)), mem[burst_addr + 16'(i)],
              burst_data[i]);
  send_byte(hci_pkg::op_cpu_mem_rd, 1'b0);
  send_word(burst_addr);
  send_word(16'(n_burst));
  for (i = 0; i < n_burst; i++)
    expect_reply(burst_data[i], "memory read");
  end_test("memory write and read", err0);

  err0 = errors;
  rand_byte(rb);
  sel = rb[3:0];
  rand_byte(reg_data);
  send_byte(hci_pkg::op_cpu_reg_wr, 1'b0);
  send_byte({4'h0, sel}, 1'b0);
  send_byte(reg_data, 1'b0);
  n = 0;
  while (reg_wr_cnt == 0 && n < frame_cyc)
  begin
    step();
    n++;
  end
  check_val("cpu_dbgreg_sel", {4'h0, reg_wr_sel}, {4'h0, sel});
  check_val("cpu_dbgreg_out", reg_wr_data, reg_data);
  rand_byte(rb);
  sel = rb[3:0];
  send_byte(hci_pkg::op_cpu_reg_rd, 1'b0);
  send_byte({4'h0, sel}, 1'b0);
  expect_reply({4'h0, sel} ^ 8'hA5, "register read");
  // Still one strobe after the read went through
  check_val("cpu_dbgreg_wr pulses", 8'(reg_wr_cnt), 8'd1);
  end_test("register access", err0);

  // Error bits are sticky
  err0 = errors;
  send_byte(8'h0B, 1'b0);            // Former PPU opcode
  send_byte(hci_pkg::op_query_err_code, 1'b0);
  expect_reply(8'h02, "error code after unknown opcode");
  send_byte(hci_pkg::op_dbg_brk, 1'b1);  // Bad parity, no effect while halted
  send_byte(hci_pkg::op_query_err_code, 1'b0);
  expect_reply(8'h03, "error code after parity error");
  end_test("error code", err0);

  $display("Tests run: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
           tests_run, tests_failed, errors, i_dut.i_checker.fail_cnt);
  if (errors == 0 && i_dut.i_checker.fail_cnt == 0)
    $display("Simulation finished: PASS");
  else
    $display("Simulation finished: FAIL");
  $finish;
end

endmodule

//--- hci_top.f
common/hci_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
cmd_engine/cmd_engine.sv
source/hci_top.sv
sim/hci_checker.sv
sim/hci_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the hci_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module hci_tb -f hci_top.f

out=$(./obj_dir/Vhci_tb +verilator+error+limit+1000)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
